/* stepper_pkg.sv */
/*
 * Register map, timing constants and state encodings of the motion peripheral.
 * Periods are counted in system clocks; the ramp constants assume a 25 MHz clock.
 */
package stepper_pkg;

  // peripheral window and word offsets
  localparam logic [31:0] io_base           = 32'h1000_0000;
  localparam logic [31:0] reg_leds          = 32'h00;
  localparam logic [31:0] reg_spi_out_upper = 32'h04;
  localparam logic [31:0] reg_spi_out_lower = 32'h08;
  localparam logic [31:0] reg_spi_in_upper  = 32'h0c;
  localparam logic [31:0] reg_spi_in_lower  = 32'h10;
  localparam logic [31:0] reg_spi_config    = 32'h14;
  localparam logic [31:0] reg_spi_status    = 32'h18;
  localparam logic [31:0] reg_move_control  = 32'h1c;
  localparam logic [31:0] reg_move_steps    = 32'h20;
  localparam logic [31:0] reg_move_status   = 32'h24;

  typedef enum logic [3:0] {
    sel_leds,
    sel_spi_out_upper,
    sel_spi_out_lower,
    sel_spi_in_upper,
    sel_spi_in_lower,
    sel_spi_config,
    sel_spi_status,
    sel_move_control,
    sel_move_steps,
    sel_move_status,
    reg_none
  } reg_sel_t;

  // spi frame engine
  localparam int spi_frame_bits = 40;
  localparam int spi_cs_count   = 12;
  localparam int spi_clk_div    = 4;
  localparam int spi_div_bits   = 2;
  localparam int spi_count_bits = 6;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift,
    spi_finish
  } spi_state_t;

  // step generation, all in clock cycles
  localparam int period_bits     = 16;
  localparam int steps_bits      = 24;
  localparam int step_pulse_bits = 4;

  localparam logic [period_bits-1:0]     start_period      = 16'd200;
  localparam logic [period_bits-1:0]     min_period        = 16'd40;
  localparam logic [period_bits-1:0]     ramp_delta        = 16'd16;
  localparam logic [step_pulse_bits-1:0] step_pulse_cycles = 4'd8;

  typedef enum logic [1:0] {
    mv_idle,
    mv_accel,
    mv_cruise,
    mv_decel
  } move_state_t;

endpackage

/* io_register_bank.sv */
/*
 * Word register bank on the valid/ready memory bus.
 * Master holds mem_valid until mem_ready; unaligned or unmapped accesses
 * still get a reply, writes are dropped and reads return zero.
 */
`timescale 1ns/1ps

module io_register_bank (
  input  logic                                    clk_in,
  input  logic                                    rst_n,
  input  logic                                    mem_valid,
  input  logic [31:0]                             mem_addr,
  input  logic [31:0]                             mem_wdata,
  input  logic [3:0]                              mem_wstrb,
  input  logic [stepper_pkg::spi_frame_bits-1:0] spi_rx_data,
  input  logic                                    spi_ready,
  input  logic                                    move_done,
  output logic                                    mem_ready,
  output logic [31:0]                             mem_rdata,
  output logic [stepper_pkg::spi_frame_bits-1:0] spi_tx_data,
  output logic [3:0]                              spi_cs_select,
  output logic                                    spi_send,
  output logic [stepper_pkg::steps_bits-1:0]     move_steps,
  output logic                                    move_dir,
  output logic                                    move_start,
  output logic [7:0]                              led
);
  import stepper_pkg::*;

  reg_sel_t    sel;
  logic        access;
  logic        wr;
  logic [31:0] wmask;
  logic [31:0] rd_mux;
  logic [7:0]  out_upper;
  logic [31:0] out_lower;

  // one reply per access, the flag blocks a second answer
  assign access = mem_valid && !mem_ready;
  assign wr     = access && (mem_wstrb != 4'b0000);
  assign wmask  = {{8{mem_wstrb[3]}}, {8{mem_wstrb[2]}}, {8{mem_wstrb[1]}}, {8{mem_wstrb[0]}}};

  assign spi_tx_data = {out_upper, out_lower};

  always_comb begin
    case (mem_addr)
      io_base + reg_leds:          sel = sel_leds;
      io_base + reg_spi_out_upper: sel = sel_spi_out_upper;
      io_base + reg_spi_out_lower: sel = sel_spi_out_lower;
      io_base + reg_spi_in_upper:  sel = sel_spi_in_upper;
      io_base + reg_spi_in_lower:  sel = sel_spi_in_lower;
      io_base + reg_spi_config:    sel = sel_spi_config;
      io_base + reg_spi_status:    sel = sel_spi_status;
      io_base + reg_move_control:  sel = sel_move_control;
      io_base + reg_move_steps:    sel = sel_move_steps;
      io_base + reg_move_status:   sel = sel_move_status;
      default:                     sel = reg_none;
    endcase
  end

  // strobe bits (config[0], control[0]) always read as zero
  always_comb begin
    case (sel)
      sel_leds:          rd_mux = {24'b0, led};
      sel_spi_out_upper: rd_mux = {24'b0, out_upper};
      sel_spi_out_lower: rd_mux = out_lower;
      sel_spi_in_upper:  rd_mux = {24'b0, spi_rx_data[39:32]};
      sel_spi_in_lower:  rd_mux = spi_rx_data[31:0];
      sel_spi_config:    rd_mux = {27'b0, spi_cs_select, 1'b0};
      sel_spi_status:    rd_mux = {31'b0, spi_ready};
      sel_move_control:  rd_mux = {30'b0, move_dir, 1'b0};
      sel_move_steps:    rd_mux = {8'b0, move_steps};
      sel_move_status:   rd_mux = {31'b0, move_done};
      default:           rd_mux = 32'b0;
    endcase
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      mem_ready     <= 1'b0;
      mem_rdata     <= 32'b0;
      led           <= 8'b0;
      spi_cs_select <= 4'b0;
      spi_send      <= 1'b0;
      move_steps    <= '0;
      move_dir      <= 1'b0;
      move_start    <= 1'b0;
    end else begin
      mem_ready  <= access;
      mem_rdata  <= access ? rd_mux : 32'b0;
      spi_send   <= wr && (sel == sel_spi_config) && mem_wstrb[0] && mem_wdata[0];
      move_start <= wr && (sel == sel_move_control) && mem_wstrb[0] && mem_wdata[0];
      if (wr) begin
        case (sel)
          sel_leds:         led <= (led & ~wmask[7:0]) | (mem_wdata[7:0] & wmask[7:0]);
          sel_spi_config:   if (mem_wstrb[0]) spi_cs_select <= mem_wdata[4:1];
          sel_move_control: if (mem_wstrb[0]) move_dir <= mem_wdata[1];
          sel_move_steps: begin
            move_steps <= (move_steps & ~wmask[23:0]) | (mem_wdata[23:0] & wmask[23:0]);
          end
          default: ;
        endcase
      end
    end
  end

  // outgoing frame data
  always_ff @(posedge clk_in) begin
    if (wr && sel == sel_spi_out_upper) begin
      out_upper <= (out_upper & ~wmask[7:0]) | (mem_wdata[7:0] & wmask[7:0]);
    end
    if (wr && sel == sel_spi_out_lower) begin
      out_lower <= (out_lower & ~wmask) | (mem_wdata & wmask);
    end
  end

  // request stays put until it is answered
  a_hold_request: assert property (@(posedge clk_in) disable iff (!rst_n)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb));

endmodule

/* spi_master.sv */
/*
 * 40-bit full-duplex SPI master, mode 0, MSB first.
 * A send while a frame is in flight is dropped; a select of 12 or more
 * runs the frame with every chip select high.
 */
`timescale 1ns/1ps

module spi_master (
  input  logic                                    clk_in,
  input  logic                                    rst_n,
  input  logic [stepper_pkg::spi_frame_bits-1:0] tx_data,
  input  logic [3:0]                              cs_select,
  input  logic                                    send,
  input  logic                                    miso,
  output logic [stepper_pkg::spi_frame_bits-1:0] rx_data,
  output logic                                    ready,
  output logic                                    sck,
  output logic                                    mosi,
  output logic [stepper_pkg::spi_cs_count-1:0]   cs_n
);
  import stepper_pkg::*;

  spi_state_t                state;
  logic [spi_frame_bits-1:0] shreg;
  logic [spi_div_bits-1:0]   div_cnt;
  logic [spi_count_bits-1:0] bit_cnt;
  logic [3:0]                cs_idx;
  logic                      miso_q;
  logic                      half_tick;
  logic                      accept;

  assign accept    = (state == spi_idle) && send && ready;
  assign half_tick = (div_cnt == spi_div_bits'(spi_clk_div - 1));

  // shared shift register, tx leaves at the top and rx enters at the bottom
  assign mosi = shreg[spi_frame_bits-1];

  assign cs_n = (state == spi_shift && cs_idx < spi_cs_count) ?
                ~(spi_cs_count'(1) << cs_idx) : '1;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state   <= spi_idle;
      ready   <= 1'b1;
      sck     <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      cs_idx  <= '0;
    end else begin
      case (state)
        spi_idle: begin
          if (accept) begin
            state   <= spi_shift;
            ready   <= 1'b0;
            cs_idx  <= cs_select;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        spi_shift: begin
          div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
          if (half_tick) begin
            sck <= ~sck;
            // falling edge ends one bit
            if (sck) begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == spi_count_bits'(spi_frame_bits - 1)) begin
                state <= spi_finish;
              end
            end
          end
        end
        spi_finish: begin
          ready <= 1'b1;
          state <= spi_idle;
        end
        default: state <= spi_idle;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      shreg <= tx_data;
    end else if (state == spi_shift && half_tick) begin
      if (!sck) begin
        miso_q <= miso;
      end else begin
        shreg <= {shreg[spi_frame_bits-2:0], miso_q};
      end
    end
    if (state == spi_finish) begin
      rx_data <= shreg;
    end
  end

  // sck rests low outside a frame
  a_sck_idle: assert property (@(posedge clk_in) disable iff (!rst_n)
    (state != spi_shift) |-> !sck);

endmodule

/* move_sequencer.sv */
/*
 * Trapezoid step planner: linear ramp down from start_period to min_period,
 * cruise, then a mirrored ramp up. A start while a move runs is ignored.
 */
`timescale 1ns/1ps

module move_sequencer (
  input  logic                                 clk_in,
  input  logic                                 rst_n,
  input  logic                                 start,
  input  logic [stepper_pkg::steps_bits-1:0]  steps,
  input  logic                                 dir_in,
  input  logic                                 period_done,
  output logic                                 done,
  output logic                                 dir,
  output logic                                 load,
  output logic [stepper_pkg::period_bits-1:0] period
);
  import stepper_pkg::*;

  move_state_t            state;
  move_state_t            state_next;
  logic [steps_bits-1:0]  left;
  logic [steps_bits-1:0]  left_now;
  logic [steps_bits-1:0]  ramp;
  logic [period_bits-1:0] period_next;
  logic                   accept;
  logic                   more;
  logic                   ramp_inc;

  assign accept = (state == mv_idle) && start && (steps != '0);
  assign more   = (state != mv_idle) && period_done && (left != '0);

  // timer reloads in the same cycle its period ends
  assign load = accept || more;

  // steps still to be started once the current load goes out
  assign left_now = accept ? steps - 1'b1 : left - 1'b1;

  // plan the period after the one being loaded now
  always_comb begin
    ramp_inc = 1'b0;
    if (left_now <= ramp) begin
      state_next  = mv_decel;
      period_next = (period > start_period - ramp_delta) ? start_period : period + ramp_delta;
    end else if (period > min_period) begin
      state_next  = mv_accel;
      ramp_inc    = 1'b1;
      period_next = (period < min_period + ramp_delta) ? min_period : period - ramp_delta;
    end else begin
      state_next  = mv_cruise;
      period_next = min_period;
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      state  <= mv_idle;
      done   <= 1'b1;
      dir    <= 1'b0;
      left   <= '0;
      ramp   <= '0;
      period <= start_period;
    end else if (load) begin
      state  <= state_next;
      period <= period_next;
      left   <= left_now;
      if (ramp_inc) begin
        ramp <= ramp + 1'b1;
      end
      if (accept) begin
        done <= 1'b0;
        dir  <= dir_in;
      end
    end else if (state != mv_idle && period_done) begin
      // last period has run out
      state  <= mv_idle;
      done   <= 1'b1;
      ramp   <= '0;
      period <= start_period;
    end
  end

  a_period_range: assert property (@(posedge clk_in) disable iff (!rst_n)
    load |-> (period >= min_period) && (period <= start_period));

endmodule

/* step_timer.sv */
/*
 * Period down-counter; step is high for the first step_pulse_cycles
 * of each period. A load in the last cycle chains periods with no gap.
 */
`timescale 1ns/1ps

module step_timer (
  input  logic                                 clk_in,
  input  logic                                 rst_n,
  input  logic                                 load,
  input  logic [stepper_pkg::period_bits-1:0] period,
  output logic                                 period_done,
  output logic                                 step
);
  import stepper_pkg::*;

  logic [period_bits-1:0]     cnt;
  logic [step_pulse_bits-1:0] pulse_cnt;
  logic                       running;

  assign period_done = running && (cnt == '0);
  assign step        = (pulse_cnt != '0);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      pulse_cnt <= '0;
      running   <= 1'b0;
    end else if (load) begin
      cnt       <= period - 1'b1;
      pulse_cnt <= step_pulse_cycles;
      running   <= 1'b1;
    end else begin
      if (pulse_cnt != '0) begin
        pulse_cnt <= pulse_cnt - 1'b1;
      end
      if (running) begin
        if (cnt == '0) begin
          running <= 1'b0;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

endmodule

/* stepper_io.sv */
/*
 * Motion peripheral top: bus register bank, SPI master and one step axis.
 * Bus follows the valid/ready handshake; a single processor is assumed.
 */
`timescale 1ns/1ps

module stepper_io (
  input  logic        clk_25mhz,
  input  logic        rst_n,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  input  logic        miso,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic        sck,
  output logic        mosi,
  output logic [11:0] cs_n,
  output logic        step,
  output logic        dir,
  output logic [7:0]  led
);
  import stepper_pkg::*;

  logic [spi_frame_bits-1:0] spi_tx_data;
  logic [spi_frame_bits-1:0] spi_rx_data;
  logic [3:0]                spi_cs_select;
  logic                      spi_send;
  logic                      spi_ready;
  logic [steps_bits-1:0]     move_steps;
  logic                      move_dir;
  logic                      move_start;
  logic                      move_done;
  logic                      tmr_load;
  logic                      period_done;
  logic [period_bits-1:0]    period;

  io_register_bank bank0 (
    .clk_in(clk_25mhz), .rst_n(rst_n),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .spi_rx_data(spi_rx_data), .spi_ready(spi_ready),
    .move_done(move_done), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .spi_tx_data(spi_tx_data), .spi_cs_select(spi_cs_select), .spi_send(spi_send),
    .move_steps(move_steps), .move_dir(move_dir), .move_start(move_start), .led(led)
  );

  spi_master spi0 (
    .clk_in(clk_25mhz), .rst_n(rst_n),
    .tx_data(spi_tx_data), .cs_select(spi_cs_select), .send(spi_send), .miso(miso),
    .rx_data(spi_rx_data), .ready(spi_ready), .sck(sck), .mosi(mosi), .cs_n(cs_n)
  );

  move_sequencer seq0 (
    .clk_in(clk_25mhz), .rst_n(rst_n),
    .start(move_start), .steps(move_steps), .dir_in(move_dir),
    .period_done(period_done), .done(move_done), .dir(dir),
    .load(tmr_load), .period(period)
  );

  step_timer tmr0 (
    .clk_in(clk_25mhz), .rst_n(rst_n),
    .load(tmr_load), .period(period), .period_done(period_done), .step(step)
  );

endmodule

/* tb_stepper.sv */
/*
 * Bus-master testbench for stepper_io, driven line by line from tb_stepper_input.txt.
 * miso is a registered loopback of mosi, so every frame should read back unchanged.
 */
`timescale 1ns/1ps

module tb_stepper;
  import stepper_pkg::*;

  logic        clk_25mhz, rst_n, mem_valid, miso, mem_ready, sck, mosi, step, dir;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic [3:0]  mem_wstrb;
  logic [11:0] cs_n, cs_seen, exp_cs_n;
  logic [7:0]  led;
  logic        exp_dir, sck_q, step_q, ready_q;
  int          errors, timeouts, cyc, gap, last_rise;
  int          sck_rises, step_rises, mid_index, mid_gap;
  integer      seed;

  stepper_io dut0 (.*);

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz;
  end

  // loopback, half a clock behind mosi
  always @(negedge clk_25mhz)
    miso <= mosi;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("[ERROR] %0d ns: %0s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // bus side monitor, sampled on the rising edge
  always @(posedge clk_25mhz) begin
    cyc++;
    if (mem_ready && ready_q)
      check_value("mem_ready high cycles", 2, 1);
    if (sck && !sck_q) begin
      sck_rises++;
      check_value("cs_n at sck rise", cs_n, exp_cs_n);
    end
    cs_seen |= ~cs_n;
    if (step && !step_q) begin
      check_value("dir at step", dir, exp_dir);
      gap = cyc - last_rise;
      if (step_rises > 0)
        check_value($sformatf("step spacing %0d in range", gap),
                    gap >= min_period && gap <= start_period, 1);
      if (step_rises == mid_index)
        mid_gap = gap;
      last_rise = cyc;
      step_rises++;
    end
    sck_q   = sck;
    step_q  = step;
    ready_q = mem_ready;
  end

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge clk_25mhz);
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    do begin
      @(posedge clk_25mhz);
      waited++;
    end while (!mem_ready && waited < 16);
    rdata = mem_rdata;
    if (!mem_ready) begin
      timeouts++;
      $display("timeout: no mem_ready reply for address %08h", addr);
    end
    @(negedge clk_25mhz);
    mem_valid = 1'b0;
    mem_wstrb = 4'b0;
  endtask

  // poll spi_ready or move_done until it reaches level
  task automatic wait_status(input bit on_spi, input logic level, input int limit);
    int waited;
    waited = 0;
    while ((on_spi ? dut0.spi_ready : dut0.move_done) !== level && waited < limit) begin
      @(posedge clk_25mhz);
      waited++;
    end
    if ((on_spi ? dut0.spi_ready : dut0.move_done) !== level) begin
      timeouts++;
      $display("timeout: %0s did not reach %0b within %0d cycles",
               on_spi ? "spi_ready" : "move_done", level, limit);
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    int          n;
    string       line;
    string       kw;
    string       dstr;
    logic [31:0] addr, mask, want, rd, hi, lo;
    logic [63:0] data;

    {errors, timeouts, cyc, gap, last_rise} = '0;
    {sck_rises, step_rises, mid_index, mid_gap} = '0;
    seed      = 32'h89eb7622;
    rst_n     = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = 32'b0;
    mem_wdata = 32'b0;
    mem_wstrb = 4'b0;
    miso      = 1'b0;
    cs_seen   = '0;
    exp_cs_n  = '1;
    {exp_dir, sck_q, step_q, ready_q} = '0;
    repeat (16) @(negedge clk_25mhz);
    rst_n = 1'b1;
    check_value("cs_n after reset", cs_n, 12'hfff);
    check_value("step after reset", step, 0);

    fd = $fopen("tb_stepper_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tb_stepper_input.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#")
          continue;
        fields = $sscanf(line, "%s %h %s %h %h", kw, addr, dstr, mask, want);
        if (dstr == "rand") begin
          hi   = $random(seed);
          lo   = $random(seed);
          data = {hi, lo};
        end else begin
          void'($sscanf(dstr, "%h", data));
        end
        if (fields != 5) begin
          $display("malformed input line: %0s", line);
          errors++;
        end else if (kw == "write") begin
          bus_access(addr, data[31:0], mask[3:0], rd);
        end else if (kw == "read") begin
          bus_access(addr, 32'b0, 4'b0, rd);
          check_value($sformatf("read at %08h", addr), rd & mask, want);
          // the led pins carry the same register
          if (addr == io_base + reg_leds)
            check_value("led pins", led, want[7:0]);
        end else if (kw == "spi") begin
          bus_access(io_base + reg_spi_out_upper, {24'b0, data[39:32]}, 4'hf, rd);
          bus_access(io_base + reg_spi_out_lower, data[31:0], 4'hf, rd);
          exp_cs_n  = ~want[11:0];
          sck_rises = 0;
          cs_seen   = '0;
          bus_access(io_base + reg_spi_config, {27'b0, addr[3:0], 1'b1}, 4'hf, rd);
          wait_status(1'b1, 1'b0, 16);
          // a second send mid-frame must be dropped
          if (mask[0]) begin
            bus_access(io_base + reg_spi_out_lower, ~data[31:0], 4'hf, rd);
            bus_access(io_base + reg_spi_config, {27'b0, addr[3:0], 1'b1}, 4'hf, rd);
          end
          wait_status(1'b1, 1'b1, 4 * spi_frame_bits * spi_clk_div);
          check_value("sck rising edges", sck_rises, spi_frame_bits);
          check_value("cs_n lines pulled low", cs_seen, want[11:0]);
          bus_access(io_base + reg_spi_in_upper, 32'b0, 4'b0, rd);
          check_value("spi_in_upper", rd, data[39:32]);
          bus_access(io_base + reg_spi_in_lower, 32'b0, 4'b0, rd);
          check_value("spi_in_lower", rd, data[31:0]);
          bus_access(io_base + reg_spi_status, 32'b0, 4'b0, rd);
          check_value("spi_status", rd, 1);
        end else if (kw == "move") begin
          n = data[31:0];
          bus_access(io_base + reg_move_steps, data[31:0], 4'hf, rd);
          exp_dir    = addr[0];
          step_rises = 0;
          mid_index  = (n - 1) / 2 + 1;
          mid_gap    = 0;
          bus_access(io_base + reg_move_control, {30'b0, addr[0], 1'b1}, 4'hf, rd);
          if (n > 0)
            wait_status(1'b0, 1'b0, 16);
          // restart with other values while the move runs
          if (mask[0]) begin
            bus_access(io_base + reg_move_steps, data[31:0] + 7, 4'hf, rd);
            bus_access(io_base + reg_move_control, {30'b0, ~addr[0], 1'b1}, 4'hf, rd);
          end
          wait_status(1'b0, 1'b1, (n + 2) * start_period);
          check_value("step pulses", step_rises, n);
          if (want != 0)
            check_value("cruise step spacing", mid_gap, want);
          bus_access(io_base + reg_move_status, 32'b0, 4'b0, rd);
          check_value("move_status", rd, 1);
        end else begin
          $display("unknown operation in input line: %0s", line);
          errors++;
        end
      end
      $fclose(fd);
    end

    $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_stepper_input.txt */
# op addr|select data|frame mask|wstrb expected, all hex; read compares rdata & mask
# spi: mask 1 resends mid-frame, expected = cs_n lines low; move: addr dir, mask restart
write 10000000 000000a5 f 0
read 10000000 0 ffffffff a5
write 10000000 ffffff3c 1 0
read 10000000 0 ffffffff 3c
write 10000000 12345678 e 0
read 10000000 0 ffffffff 3c
write 10000004 aabbccdd f 0
read 10000004 0 ffffffff dd
write 10000008 01234567 f 0
write 10000008 ffffffff 4 0
read 10000008 0 ffffffff 01ff4567
write 10000020 89abcdef f 0
write 10000020 00000012 2 0
read 10000020 0 ffffffff ab00ef
write 10000018 ffffffff f 0
read 10000018 0 ffffffff 1
write 10000024 00000000 f 0
read 10000024 0 ffffffff 1
write 1000001c 00000002 f 0
read 1000001c 0 ffffffff 2
write 10000014 00000018 f 0
read 10000014 0 ffffffff 18
write 10000040 ffffffff f 0
read 10000040 0 ffffffff 0
read 10000002 0 ffffffff 0
spi 3 a5c3e1f00f 0 008
spi 7 rand 1 080
spi c rand 0 000
spi 0 rand 0 001
spi b 123456789a 1 800
move 1 28 1 28
move 0 5 0 0
move 1 0 0 0
move 0 3 1 0
read 10000024 0 ffffffff 1
read 10000018 0 ffffffff 1

/* tb.f */
stepper_pkg.sv
io_register_bank.sv
spi_master.sv
move_sequencer.sv
step_timer.sv
stepper_io.sv
tb_stepper.sv
